// ==== hdl/soc_pkg.sv ====
package soc_pkg;

  // Backing memory and cache geometry
  localparam int MEM_ADDR_WIDTH = 16;
  localparam int LINE_BYTES = 16;
  localparam int CACHE_LINES = 256;
  localparam int INDEX_WIDTH = 8;
  localparam int OFFSET_WIDTH = 4;
  localparam int TAG_WIDTH = MEM_ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
  localparam int WORD_SEL_WIDTH = OFFSET_WIDTH - 2;
  localparam int MEM_LINE_WIDTH = MEM_ADDR_WIDTH - OFFSET_WIDTH;
  localparam int MEM_LINES = 1 << MEM_LINE_WIDTH;

  // Address map
  localparam int IO_BASE_BIT = 31;
  localparam int IO_OFS_WIDTH = 4;
  localparam logic [IO_OFS_WIDTH-1:0] IO_LED_OFS = 4'h0;
  localparam logic [IO_OFS_WIDTH-1:0] IO_UART_DATA_OFS = 4'h4;
  localparam logic [IO_OFS_WIDTH-1:0] IO_UART_STAT_OFS = 4'h8;

  // Short UART bit time for simulation
  localparam int CLKS_PER_BIT = 8;
  localparam int BAUD_CNT_WIDTH = $clog2(CLKS_PER_BIT);
  localparam int UART_FRAME_BITS = 10;

  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [3:0] strb_t;
  typedef logic [LINE_BYTES*8-1:0] line_t;
  typedef logic [LINE_BYTES-1:0] line_strb_t;
  typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;
  typedef logic [TAG_WIDTH-1:0] tag_t;
  typedef logic [INDEX_WIDTH-1:0] index_t;
  typedef logic [WORD_SEL_WIDTH-1:0] word_sel_t;
  typedef logic [IO_OFS_WIDTH-1:0] io_ofs_t;

  typedef struct packed {
    addr_t addr;
    logic  we;
    strb_t wstrb;
    word_t wdata;
  } cpu_req_t;

  // Line-aligned byte address for AR and AW
  typedef struct packed {mem_addr_t addr;} axi_addr_t;

  typedef struct packed {
    line_t      data;
    line_strb_t strb;
  } axi_w_t;

  typedef struct packed {
    line_t      data;
    logic [1:0] resp;
  } axi_r_t;

  typedef struct packed {
    io_ofs_t ofs;
    logic    we;
    word_t   wdata;
    strb_t   wstrb;
  } io_req_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    FILL_AR,
    FILL_R,
    WR_AW,
    WR_B,
    IO_REQ,
    IO_RSP
  } ctrl_state_t;

endpackage

// ==== hdl/soc_bus_ctrl.sv ====
module soc_bus_ctrl
  import soc_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      cpu_req_valid,
  output logic      cpu_req_ready,
  input  cpu_req_t  cpu_req,
  output logic      cpu_rsp_valid,
  output word_t     cpu_rsp_rdata,
  output index_t    rd_index,
  input  logic      rd_valid,
  input  tag_t      rd_tag,
  input  line_t     rd_line,
  output logic      wr_en,
  output index_t    wr_index,
  output tag_t      wr_tag,
  output line_t     wr_line,
  output logic      ar_valid,
  input  logic      ar_ready,
  output axi_addr_t ar,
  input  logic      r_valid,
  output logic      r_ready,
  input  axi_r_t    r,
  output logic      aw_valid,
  input  logic      aw_ready,
  output axi_addr_t aw,
  output logic      w_valid,
  input  logic      w_ready,
  output axi_w_t    w,
  input  logic      b_valid,
  output logic      b_ready,
  output logic      io_valid,
  input  logic      io_ready,
  output io_req_t   io_req,
  input  logic      io_rsp_valid,
  input  word_t     io_rdata
);

  ctrl_state_t state_q;
  cpu_req_t    req_q;
  logic        aw_done_q;
  logic        w_done_q;
  logic        rsp_valid_q;
  word_t       rsp_rdata_q;

  tag_t        req_tag;
  index_t      req_index;
  word_sel_t   req_word;
  mem_addr_t   line_addr;
  logic        hit;
  logic        aw_fire;
  logic        w_fire;
  line_strb_t  line_strb;
  line_t       wr_data_line;
  line_t       merged_line;

  function automatic word_t line_word(line_t line, word_sel_t sel);
    return line[sel*32+:32];
  endfunction

  assign req_tag = req_q.addr[MEM_ADDR_WIDTH-1-:TAG_WIDTH];
  assign req_index = req_q.addr[OFFSET_WIDTH+:INDEX_WIDTH];
  assign req_word = req_q.addr[OFFSET_WIDTH-1:2];
  assign line_addr = {req_q.addr[MEM_ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
  assign hit = rd_valid && (rd_tag == req_tag);

  assign cpu_req_ready = (state_q == IDLE);
  assign cpu_rsp_valid = rsp_valid_q;
  assign cpu_rsp_rdata = rsp_rdata_q;

  // Index the array straight from the request so tags are ready in LOOKUP
  assign rd_index = (state_q == IDLE) ? cpu_req.addr[OFFSET_WIDTH+:INDEX_WIDTH] : req_index;

  // Word write expanded to a full line with a shifted strobe
  assign line_strb = line_strb_t'(req_q.wstrb) << {req_word, 2'b00};
  assign wr_data_line = {(LINE_BYTES / 4) {req_q.wdata}};

  always_comb begin
    for (int i = 0; i < LINE_BYTES; i++) begin
      merged_line[i*8+:8] = line_strb[i] ? wr_data_line[i*8+:8] : rd_line[i*8+:8];
    end
  end

  // Fill on read miss, merge on write hit; write misses do not allocate
  assign wr_en = ((state_q == LOOKUP) && req_q.we && hit) || ((state_q == FILL_R) && r_valid);
  assign wr_index = req_index;
  assign wr_tag = req_tag;
  assign wr_line = (state_q == FILL_R) ? r.data : merged_line;

  assign ar_valid = (state_q == FILL_AR);
  assign ar = '{addr: line_addr};
  assign r_ready = (state_q == FILL_R);

  assign aw_valid = (state_q == WR_AW) && !aw_done_q;
  assign w_valid = (state_q == WR_AW) && !w_done_q;
  assign aw = '{addr: line_addr};
  assign w = '{data: wr_data_line, strb: line_strb};
  assign aw_fire = aw_valid && aw_ready;
  assign w_fire = w_valid && w_ready;
  assign b_ready = (state_q == WR_B);

  assign io_valid = (state_q == IO_REQ);
  assign io_req = '{
          ofs: req_q.addr[IO_OFS_WIDTH-1:0],
          we: req_q.we,
          wdata: req_q.wdata,
          wstrb: req_q.wstrb
      };

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= IDLE;
      aw_done_q   <= 1'b0;
      w_done_q    <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (cpu_req_valid) begin
            state_q <= cpu_req.addr[IO_BASE_BIT] ? IO_REQ : LOOKUP;
          end
        end
        LOOKUP: begin
          if (req_q.we) begin
            state_q <= WR_AW;
          end else if (hit) begin
            rsp_valid_q <= 1'b1;
            state_q     <= IDLE;
          end else begin
            state_q <= FILL_AR;
          end
        end
        FILL_AR: begin
          if (ar_ready) state_q <= FILL_R;
        end
        FILL_R: begin
          if (r_valid) begin
            rsp_valid_q <= 1'b1;
            state_q     <= IDLE;
          end
        end
        WR_AW: begin
          if ((aw_done_q || aw_fire) && (w_done_q || w_fire)) begin
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
            state_q   <= WR_B;
          end else begin
            aw_done_q <= aw_done_q || aw_fire;
            w_done_q  <= w_done_q || w_fire;
          end
        end
        WR_B: begin
          if (b_valid) begin
            rsp_valid_q <= 1'b1;
            state_q     <= IDLE;
          end
        end
        IO_REQ: begin
          if (io_ready) state_q <= IO_RSP;
        end
        IO_RSP: begin
          if (io_rsp_valid) begin
            rsp_valid_q <= 1'b1;
            state_q     <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cpu_req_valid && cpu_req_ready) begin
      req_q <= cpu_req;
    end
    case (state_q)
      LOOKUP: rsp_rdata_q <= line_word(rd_line, req_word);
      FILL_R: rsp_rdata_q <= line_word(r.data, req_word);
      WR_B: rsp_rdata_q <= '0;
      IO_RSP: rsp_rdata_q <= io_rdata;
      default: rsp_rdata_q <= rsp_rdata_q;
    endcase
  end

endmodule

// ==== hdl/dcache_array.sv ====
module dcache_array
  import soc_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  index_t rd_index,
  output logic   rd_valid,
  output tag_t   rd_tag,
  output line_t  rd_line,
  input  logic   wr_en,
  input  index_t wr_index,
  input  tag_t   wr_tag,
  input  line_t  wr_line
);

  tag_t                   tag_mem [CACHE_LINES];
  line_t                  line_mem[CACHE_LINES];
  logic [CACHE_LINES-1:0] valid_q;

  // Valid bits track which lines hold filled data
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q  <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= valid_q[rd_index];
      if (wr_en) begin
        valid_q[wr_index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    rd_tag  <= tag_mem[rd_index];
    rd_line <= line_mem[rd_index];
    if (wr_en) begin
      tag_mem[wr_index]  <= wr_tag;
      line_mem[wr_index] <= wr_line;
    end
  end

endmodule

// ==== hdl/axi_line_mem.sv ====
module axi_line_mem
  import soc_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      ar_valid,
  output logic      ar_ready,
  input  axi_addr_t ar,
  output logic      r_valid,
  input  logic      r_ready,
  output axi_r_t    r,
  input  logic      aw_valid,
  output logic      aw_ready,
  input  axi_addr_t aw,
  input  logic      w_valid,
  output logic      w_ready,
  input  axi_w_t    w,
  output logic      b_valid,
  input  logic      b_ready
);

  line_t     mem[MEM_LINES];
  line_t     rdata_q;
  axi_addr_t aw_q;
  axi_w_t    w_q;
  logic      aw_held_q;
  logic      w_held_q;

  logic      ar_fire;
  logic      aw_fire;
  logic      w_fire;
  logic      wr_go;
  mem_addr_t wr_addr;
  axi_w_t    wr_beat;

  initial begin
    for (int i = 0; i < MEM_LINES; i++) begin
      mem[i] = '0;
    end
  end

  // One outstanding read beat held until taken
  assign ar_ready = !r_valid;
  assign ar_fire = ar_valid && ar_ready;
  assign r = '{data: rdata_q, resp: AXI_RESP_OKAY};

  // AW and W are taken independently; the write lands once both are in
  assign aw_ready = !aw_held_q && !b_valid;
  assign w_ready = !w_held_q && !b_valid;
  assign aw_fire = aw_valid && aw_ready;
  assign w_fire = w_valid && w_ready;
  assign wr_go = (aw_held_q || aw_fire) && (w_held_q || w_fire);
  assign wr_addr = aw_held_q ? aw_q.addr : aw.addr;
  assign wr_beat = w_held_q ? w_q : w;

  always_ff @(posedge clk) begin
    if (rst) begin
      r_valid   <= 1'b0;
      b_valid   <= 1'b0;
      aw_held_q <= 1'b0;
      w_held_q  <= 1'b0;
    end else begin
      if (ar_fire) begin
        r_valid <= 1'b1;
      end else if (r_ready) begin
        r_valid <= 1'b0;
      end

      if (b_valid && b_ready) begin
        b_valid <= 1'b0;
      end
      if (wr_go) begin
        b_valid   <= 1'b1;
        aw_held_q <= 1'b0;
        w_held_q  <= 1'b0;
      end else begin
        if (aw_fire) aw_held_q <= 1'b1;
        if (w_fire) w_held_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      rdata_q <= mem[ar.addr[MEM_ADDR_WIDTH-1:OFFSET_WIDTH]];
    end
    if (aw_fire) aw_q <= aw;
    if (w_fire) w_q <= w;
    if (wr_go) begin
      for (int i = 0; i < LINE_BYTES; i++) begin
        if (wr_beat.strb[i]) begin
          mem[wr_addr[MEM_ADDR_WIDTH-1:OFFSET_WIDTH]][i*8+:8] <= wr_beat.data[i*8+:8];
        end
      end
    end
  end

endmodule

// ==== hdl/io_reg_bank.sv ====
module io_reg_bank
  import soc_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       io_valid,
  output logic       io_ready,
  input  io_req_t    io_req,
  output logic       io_rsp_valid,
  output word_t      io_rdata,
  output logic [3:0] led,
  output logic       tx_start,
  output logic [7:0] tx_byte,
  input  logic       tx_busy
);

  logic uart_busy;
  logic uart_wr;
  logic io_fire;

  // Busy covers the start pulse too, before the serializer raises tx_busy
  assign uart_busy = tx_busy || tx_start;
  assign uart_wr = io_req.we && (io_req.ofs == IO_UART_DATA_OFS);
  assign io_ready = !(uart_wr && uart_busy);
  assign io_fire = io_valid && io_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      led          <= '0;
      tx_start     <= 1'b0;
      io_rsp_valid <= 1'b0;
    end else begin
      io_rsp_valid <= io_fire;
      tx_start     <= io_fire && uart_wr && io_req.wstrb[0];
      if (io_fire && io_req.we && (io_req.ofs == IO_LED_OFS) && io_req.wstrb[0]) begin
        led <= io_req.wdata[3:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (io_fire && uart_wr) begin
      tx_byte <= io_req.wdata[7:0];
    end
    if (io_fire) begin
      io_rdata <= '0;
      if (!io_req.we) begin
        case (io_req.ofs)
          IO_LED_OFS: io_rdata <= {28'b0, led};
          IO_UART_STAT_OFS: io_rdata <= {31'b0, uart_busy};
          default: io_rdata <= '0;
        endcase
      end
    end
  end

endmodule

// ==== hdl/uart_tx.sv ====
module uart_tx
  import soc_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx_busy,
  output logic       uart_tx
);

  logic [BAUD_CNT_WIDTH-1:0]  baud_cnt_q;
  logic [3:0]                 bit_cnt_q;
  logic [UART_FRAME_BITS-1:0] shift_q;
  logic                       bit_done;

  assign bit_done = (baud_cnt_q == BAUD_CNT_WIDTH'(CLKS_PER_BIT - 1));

  // Line idles high between frames
  assign uart_tx = tx_busy ? shift_q[0] : 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      tx_busy    <= 1'b0;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
    end else if (!tx_busy) begin
      if (tx_start) begin
        tx_busy    <= 1'b1;
        baud_cnt_q <= '0;
        bit_cnt_q  <= '0;
      end
    end else if (bit_done) begin
      baud_cnt_q <= '0;
      if (bit_cnt_q == 4'(UART_FRAME_BITS - 1)) begin
        tx_busy <= 1'b0;
      end else begin
        bit_cnt_q <= bit_cnt_q + 4'd1;
      end
    end else begin
      baud_cnt_q <= baud_cnt_q + 1'b1;
    end
  end

  // Stop, data LSB first, start
  always_ff @(posedge clk) begin
    if (!tx_busy && tx_start) begin
      shift_q <= {1'b1, tx_byte, 1'b0};
    end else if (tx_busy && bit_done) begin
      shift_q <= {1'b1, shift_q[UART_FRAME_BITS-1:1]};
    end
  end

endmodule

// ==== hdl/soc_top.sv ====
module soc_top
  import soc_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       cpu_req_valid,
  output logic       cpu_req_ready,
  input  cpu_req_t   cpu_req,
  output logic       cpu_rsp_valid,
  output word_t      cpu_rsp_rdata,
  output logic [3:0] led,
  output logic       uart_tx
);

  // Cache array
  index_t    rd_index;
  logic      rd_valid;
  tag_t      rd_tag;
  line_t     rd_line;
  logic      wr_en;
  index_t    wr_index;
  tag_t      wr_tag;
  line_t     wr_line;

  // Single-beat AXI to the line memory
  logic      ar_valid;
  logic      ar_ready;
  axi_addr_t ar;
  logic      r_valid;
  logic      r_ready;
  axi_r_t    r;
  logic      aw_valid;
  logic      aw_ready;
  axi_addr_t aw;
  logic      w_valid;
  logic      w_ready;
  axi_w_t    w;
  logic      b_valid;
  logic      b_ready;

  // I/O bank and UART
  logic      io_valid;
  logic      io_ready;
  io_req_t   io_req;
  logic      io_rsp_valid;
  word_t     io_rdata;
  logic      tx_start;
  logic [7:0] tx_byte;
  logic      tx_busy;

  soc_bus_ctrl u_ctrl (.*);

  dcache_array u_dcache (.*);

  axi_line_mem u_mem (.*);

  io_reg_bank u_io (.*);

  uart_tx u_uart (.*);

endmodule

// ==== tb/soc_checker.sv ====
module soc_checker
  import soc_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       cpu_req_valid,
  input  logic       cpu_req_ready,
  input  cpu_req_t   cpu_req,
  input  logic       cpu_rsp_valid,
  input  word_t      cpu_rsp_rdata,
  input  logic [3:0] led,
  input  logic       uart_tx,
  output int         rsp_errors,
  output int         uart_errors,
  output int         led_errors,
  output int         uart_pending
);

  localparam int HIT_LATENCY = 2;
  localparam int MAX_UART = 64;

  logic [7:0] ref_mem[1 << MEM_ADDR_WIDTH];
  tag_t       cache_tag[CACHE_LINES];
  logic       cache_v[CACHE_LINES];
  logic [3:0] exp_led;
  logic [7:0] uart_exp[MAX_UART];
  int         uart_wr_cnt;
  int         uart_rx_cnt;
  int         cycle;

  // One entry per accepted request
  // A latency of 0 skips the timing check
  word_t exp_data_q[$];
  logic  exp_cmp_q[$];
  int    exp_lat_q[$];
  int    accept_q[$];

  assign uart_pending = uart_wr_cnt - uart_rx_cnt;

  function automatic word_t ref_read(addr_t a);
    mem_addr_t base;
    base = {a[MEM_ADDR_WIDTH-1:2], 2'b00};
    return {ref_mem[base+3], ref_mem[base+2], ref_mem[base+1], ref_mem[base]};
  endfunction

  task automatic expect_rsp(word_t data, logic cmp, int lat);
    exp_data_q.push_back(data);
    exp_cmp_q.push_back(cmp);
    exp_lat_q.push_back(lat);
    accept_q.push_back(cycle);
  endtask

  initial begin
    for (int i = 0; i < (1 << MEM_ADDR_WIDTH); i++) ref_mem[i] = '0;
    for (int i = 0; i < CACHE_LINES; i++) cache_v[i] = 1'b0;
    exp_led = '0;
    uart_wr_cnt = 0;
    uart_rx_cnt = 0;
    cycle = 0;
    rsp_errors = 0;
    uart_errors = 0;
    led_errors = 0;
  end

  always @(posedge clk) begin : monitor
    addr_t  a;
    index_t idx;
    tag_t   tag;
    int     lat;
    word_t  exp;
    cycle = cycle + 1;
    // Only one request may be in flight
    if (!rst && cpu_req_ready && !cpu_rsp_valid && exp_data_q.size() != 0) begin
      $display("ERROR time=%0t: cpu_req_ready high while a request is outstanding", $time);
      rsp_errors++;
    end
    if (!rst && cpu_rsp_valid) begin
      if (exp_data_q.size() == 0) begin
        $display("ERROR time=%0t: response arrived with no outstanding request", $time);
        rsp_errors++;
      end else begin
        exp = exp_data_q.pop_front();
        lat = cycle - accept_q.pop_front();
        if (exp_cmp_q.pop_front() && cpu_rsp_rdata !== exp) begin
          $display("MISMATCH time=%0t signal=cpu_rsp_rdata expected=%h actual=%h",
                   $time, exp, cpu_rsp_rdata);
          rsp_errors++;
        end
        if (exp_lat_q[0] != 0 && lat != exp_lat_q[0]) begin
          $display("MISMATCH time=%0t signal=cpu_rsp_valid latency expected=%0d actual=%0d",
                   $time, exp_lat_q[0], lat);
          rsp_errors++;
        end
        void'(exp_lat_q.pop_front());
      end
      if (led !== exp_led) begin
        $display("MISMATCH time=%0t signal=led expected=%h actual=%h", $time, exp_led, led);
        led_errors++;
      end
    end
    if (!rst && cpu_req_valid && cpu_req_ready) begin
      a = cpu_req.addr;
      idx = a[OFFSET_WIDTH+:INDEX_WIDTH];
      tag = a[MEM_ADDR_WIDTH-1-:TAG_WIDTH];
      if (a[IO_BASE_BIT] && cpu_req.we) begin
        if (a[IO_OFS_WIDTH-1:0] == IO_LED_OFS && cpu_req.wstrb[0]) exp_led = cpu_req.wdata[3:0];
        if (a[IO_OFS_WIDTH-1:0] == IO_UART_DATA_OFS && cpu_req.wstrb[0]) begin
          uart_exp[uart_wr_cnt % MAX_UART] <= cpu_req.wdata[7:0];
          uart_wr_cnt <= uart_wr_cnt + 1;
        end
        expect_rsp('0, 1'b0, 0);
      end else if (a[IO_BASE_BIT]) begin
        case (a[IO_OFS_WIDTH-1:0])
          IO_LED_OFS: expect_rsp({28'b0, exp_led}, 1'b1, 0);
          IO_UART_STAT_OFS: expect_rsp({31'b0, uart_wr_cnt != uart_rx_cnt}, 1'b1, 0);
          default: expect_rsp('0, 1'b1, 0);
        endcase
      end else if (cpu_req.we) begin
        for (int i = 0; i < 4; i++) begin
          if (cpu_req.wstrb[i]) ref_mem[{a[MEM_ADDR_WIDTH-1:2], 2'(i)}] = cpu_req.wdata[i*8+:8];
        end
        expect_rsp('0, 1'b0, 0);
      end else begin
        // Only reads allocate
        expect_rsp(ref_read(a), 1'b1, (cache_v[idx] && cache_tag[idx] == tag) ? HIT_LATENCY : 0);
        cache_v[idx] = 1'b1;
        cache_tag[idx] = tag;
      end
    end
  end

  // Samples each bit in its middle by counting from the start bit's falling edge
  always @(posedge clk) begin : uart_decode
    logic [7:0] rx_byte;
    logic [7:0] exp_byte;
    if (!rst && uart_tx === 1'b0) begin
      repeat (CLKS_PER_BIT / 2 - 1) @(posedge clk);
      for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(posedge clk);
        rx_byte[i] = uart_tx;
      end
      repeat (CLKS_PER_BIT) @(posedge clk);
      if (uart_tx !== 1'b1) begin
        $display("ERROR time=%0t: UART frame has a bad stop bit", $time);
        uart_errors++;
      end
      // Frame counts as done once the stop bit has fully ended
      repeat (CLKS_PER_BIT / 2 + 1) @(posedge clk);
      if (uart_rx_cnt >= uart_wr_cnt) begin
        $display("ERROR time=%0t: UART frame sent with no data write pending", $time);
        uart_errors++;
      end else begin
        exp_byte = uart_exp[uart_rx_cnt % MAX_UART];
        if (rx_byte !== exp_byte) begin
          $display("MISMATCH time=%0t signal=uart_tx expected=%h actual=%h",
                   $time, exp_byte, rx_byte);
          uart_errors++;
        end
        uart_rx_cnt <= uart_rx_cnt + 1;
      end
    end
  end

endmodule

// ==== tb/tb_soc_top.sv ====
module tb_soc_top
  import soc_pkg::*;
();

  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 8;
  localparam int RAND_PAIRS = 16;
  localparam int UART_BYTES = 3;
  // Random pairs, same line, partial merge, conflict, LED, UART with two status reads
  localparam int NUM_OPS = 2 * RAND_PAIRS + 6 + 18 + 16 + 8 + UART_BYTES + 2;
  localparam int TIMEOUT_CYCLES = NUM_OPS * 40 + UART_BYTES * 10 * CLKS_PER_BIT * 2;
  localparam addr_t IO_BASE = 32'h8000_0000;

  logic       clk;
  logic       rst;
  logic       cpu_req_valid;
  logic       cpu_req_ready;
  cpu_req_t   cpu_req;
  logic       cpu_rsp_valid;
  word_t      cpu_rsp_rdata;
  logic [3:0] led;
  logic       uart_tx;
  int         rsp_errors;
  int         uart_errors;
  int         led_errors;
  int         uart_pending;
  int         timeout_errors = 0;
  integer     seed;

  soc_top u_dut (.*);

  soc_checker u_chk (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic cpu_access(addr_t addr, logic we, strb_t strb, word_t data);
    @(posedge clk);
    cpu_req_valid <= 1'b1;
    cpu_req <= '{addr: addr, we: we, wstrb: strb, wdata: data};
    @(posedge clk);
    while (!cpu_req_ready) @(posedge clk);
    cpu_req_valid <= 1'b0;
    while (!cpu_rsp_valid) @(posedge clk);
  endtask

  task automatic cpu_write(addr_t addr, strb_t strb, word_t data);
    cpu_access(addr, 1'b1, strb, data);
  endtask

  task automatic cpu_read(addr_t addr);
    cpu_access(addr, 1'b0, '0, '0);
  endtask

  task automatic run_random_pairs();
    addr_t addr;
    word_t data;
    for (int i = 0; i < RAND_PAIRS; i++) begin
      addr = addr_t'($random(seed)) & 32'h0000_fffc;
      data = word_t'($random(seed));
      cpu_write(addr, 4'hf, data);
      cpu_read(addr);
    end
  endtask

  task automatic run_same_line();
    addr_t base;
    base = 32'h0000_1230;
    cpu_write(base + 4, 4'hf, word_t'($random(seed)));
    for (int i = 0; i < 5; i++) cpu_read(base + addr_t'((i % 4) * 4));
  endtask

  task automatic run_partial_merge();
    addr_t base;
    addr_t addr;
    strb_t strb;
    base = 32'h0000_2040;
    cpu_read(base);
    for (int i = 0; i < 8; i++) begin
      addr = base | ((addr_t'($random(seed)) & 32'h3) << 2);
      strb = strb_t'($random(seed));
      cpu_write(addr, strb, word_t'($random(seed)));
    end
    for (int i = 0; i < 4; i++) cpu_read(base + addr_t'(i * 4));
    // Same index, other tag, so the next reads refill from memory
    cpu_read(base + 32'h1000);
    for (int i = 0; i < 4; i++) cpu_read(base + addr_t'(i * 4));
  endtask

  task automatic run_conflict();
    addr_t a;
    addr_t b;
    a = 32'h0000_0500;
    b = 32'h0000_8500;
    for (int i = 0; i < 4; i++) begin
      cpu_write(a, 4'hf, word_t'($random(seed)));
      cpu_read(a);
      cpu_write(b, 4'hf, word_t'($random(seed)));
      cpu_read(b);
    end
  endtask

  task automatic run_led();
    for (int i = 0; i < 4; i++) begin
      cpu_write(IO_BASE | 32'(IO_LED_OFS), 4'h1, word_t'($random(seed)));
      cpu_read(IO_BASE | 32'(IO_LED_OFS));
    end
  endtask

  task automatic run_uart();
    cpu_write(IO_BASE | 32'(IO_UART_DATA_OFS), 4'h1, word_t'($random(seed)));
    // Stalls in the I/O bank until the first frame is out
    cpu_write(IO_BASE | 32'(IO_UART_DATA_OFS), 4'h1, word_t'($random(seed)));
    cpu_read(IO_BASE | 32'(IO_UART_STAT_OFS));
    cpu_write(IO_BASE | 32'(IO_UART_DATA_OFS), 4'h1, word_t'($random(seed)));
    while (uart_pending != 0) @(posedge clk);
    cpu_read(IO_BASE | 32'(IO_UART_STAT_OFS));
  endtask

  task automatic finish_run();
    int total;
    total = rsp_errors + uart_errors + led_errors + timeout_errors;
    $display("Error counts: response=%0d uart=%0d led=%0d timeout=%0d",
             rsp_errors, uart_errors, led_errors, timeout_errors);
    if (total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  initial begin
    seed = 34;
    clk = 1'b0;
    rst = 1'b1;
    cpu_req_valid = 1'b0;
    cpu_req = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    run_random_pairs();
    run_same_line();
    run_partial_merge();
    run_conflict();
    run_led();
    run_uart();
    repeat (2) @(posedge clk);
    finish_run();
  end

  initial begin : watchdog
    #((RESET_CYCLES + TIMEOUT_CYCLES) * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    timeout_errors = timeout_errors + 1;
    finish_run();
  end

endmodule

// ==== files.f ====
hdl/soc_pkg.sv
hdl/soc_bus_ctrl.sv
hdl/dcache_array.sv
hdl/axi_line_mem.sv
hdl/io_reg_bank.sv
hdl/uart_tx.sv
hdl/soc_top.sv
tb/soc_checker.sv
tb/tb_soc_top.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_soc_top -o sim_soc \
  > build.log 2>&1 && ./obj_dir/sim_soc > sim.log 2>&1 || echo "Build or run error"
cat sim.log 2>/dev/null
grep -q '^Simulation PASSED$' sim.log 2>/dev/null && exit 0 || exit 1
